// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [4:0] reg_addr_t;

    localparam word_t reset_pc = 32'h1000_0000;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111
    } opcode_t;

    typedef enum logic [3:0] {
        add, sub, sll, srl, sra, and_op, or_op, xor_op,
        lt, ltu, ge, geu, eq, ne
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch_setup,
        st_fetch,
        st_decode,
        st_mem_load,
        st_load_wait,
        st_mem_store,
        st_writeback,
        st_fault
    } core_state_t;

    typedef enum logic [1:0] {
        sel_reg,
        sel_imm,
        sel_pc,
        sel_shamt
    } operand_sel_t;

    typedef struct packed {
        word_t    addr;
        word_t    write_data;
        byte_en_t byte_enable;
        logic     write_req;
        logic     read_req;
    } mem_req_t;

    typedef struct packed {
        opcode_t      opcode;
        reg_addr_t    rd;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        logic [2:0]   funct3;
        alu_op_t      alu_op;
        operand_sel_t lhs_sel;
        operand_sel_t rhs_sel;
        word_t        imm;
        word_t        branch_offset;
        logic         illegal;
    } decoded_t;

endpackage

`default_nettype wire

// File: source/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   lhs,
    input  rv_pkg::word_t   rhs,
    output rv_pkg::word_t   res
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = rhs[4:0];

    always_comb begin
        case (op)
            add:     res = lhs + rhs;
            sub:     res = lhs - rhs;
            sll:     res = lhs << shamt;
            srl:     res = lhs >> shamt;
            sra:     res = word_t'($signed(lhs) >>> shamt);
            and_op:  res = lhs & rhs;
            or_op:   res = lhs | rhs;
            xor_op:  res = lhs ^ rhs;
            // comparisons land in bit 0, used for branch decisions
            lt:      res = {{(xlen-1){1'b0}}, $signed(lhs) < $signed(rhs)};
            ltu:     res = {{(xlen-1){1'b0}}, lhs < rhs};
            ge:      res = {{(xlen-1){1'b0}}, $signed(lhs) >= $signed(rhs)};
            geu:     res = {{(xlen-1){1'b0}}, lhs >= rhs};
            eq:      res = {{(xlen-1){1'b0}}, lhs == rhs};
            ne:      res = {{(xlen-1){1'b0}}, lhs != rhs};
            default: res = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  rv_pkg::word_t    instruction,
    output rv_pkg::decoded_t decoded
);
    import rv_pkg::*;

    logic [6:0] opcode_bits;
    logic [2:0] funct3;
    word_t imm_i, imm_s, imm_u, imm_j;
    alu_op_t arith_op;

    assign opcode_bits = instruction[6:0];
    assign funct3 = instruction[14:12];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_u = {instruction[31:12], 12'h000};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};

    // bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  arith_op = instruction[30] ? sub : add;
            3'b001:  arith_op = sll;
            3'b010:  arith_op = lt;
            3'b011:  arith_op = ltu;
            3'b100:  arith_op = xor_op;
            3'b101:  arith_op = instruction[30] ? sra : srl;
            3'b110:  arith_op = or_op;
            default: arith_op = and_op;
        endcase
    end

    always_comb begin
        decoded = '0;
        decoded.opcode = opcode_t'(opcode_bits);
        decoded.rd = instruction[11:7];
        decoded.rs1 = instruction[19:15];
        decoded.rs2 = instruction[24:20];
        decoded.funct3 = funct3;
        decoded.branch_offset = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                                 instruction[11:8], 1'b0};
        decoded.alu_op = add;
        decoded.lhs_sel = sel_reg;
        decoded.rhs_sel = sel_reg;
        decoded.imm = imm_i;

        case (opcode_bits)
            op_lui: begin
                // rs1 forced to x0 so the add yields the bare immediate
                decoded.rs1 = '0;
                decoded.rhs_sel = sel_imm;
                decoded.imm = imm_u;
            end
            op_auipc: begin
                decoded.lhs_sel = sel_pc;
                decoded.rhs_sel = sel_imm;
                decoded.imm = imm_u;
            end
            op_jal: begin
                decoded.lhs_sel = sel_pc;
                decoded.rhs_sel = sel_imm;
                decoded.imm = imm_j;
            end
            op_jalr, op_load: begin
                decoded.rhs_sel = sel_imm;
            end
            op_store: begin
                decoded.rhs_sel = sel_imm;
                decoded.imm = imm_s;
            end
            op_branch: begin
                case (funct3)
                    3'b000:  decoded.alu_op = eq;
                    3'b001:  decoded.alu_op = ne;
                    3'b100:  decoded.alu_op = lt;
                    3'b101:  decoded.alu_op = ge;
                    3'b110:  decoded.alu_op = ltu;
                    3'b111:  decoded.alu_op = geu;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            op_imm: begin
                // no subi, so bit 30 only matters for shifts
                decoded.alu_op = (funct3 == 3'b000) ? add : arith_op;
                decoded.rhs_sel = (funct3[1:0] == 2'b01) ? sel_shamt : sel_imm;
            end
            op_reg: begin
                decoded.alu_op = arith_op;
            end
            op_fence: begin
                decoded.alu_op = add;
            end
            default: decoded.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  wire                clk,
    input  wire                reset_n,
    input  rv_pkg::reg_addr_t  rs1,
    input  rv_pkg::reg_addr_t  rs2,
    output rv_pkg::word_t      rs1_value,
    output rv_pkg::word_t      rs2_value,
    input  wire                write_enable,
    input  rv_pkg::reg_addr_t  rd,
    input  rv_pkg::word_t      rd_value
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
    input  rv_pkg::word_t    ea,
    input  wire [2:0]        funct3,
    input  rv_pkg::word_t    store_value,
    input  rv_pkg::word_t    load_word,
    output rv_pkg::word_t    store_data,
    output rv_pkg::byte_en_t byte_enable,
    output rv_pkg::word_t    load_value,
    output logic             misaligned
);
    import rv_pkg::*;

    logic [4:0] lane_shift;
    word_t load_lanes;

    // byte offset within the word, in bits
    assign lane_shift = {ea[1:0], 3'b000};

    // low bytes of rs2 move up into the addressed lanes
    assign store_data = store_value << lane_shift;

    // funct3[1:0] gives the access size for loads and stores alike
    always_comb begin
        case (funct3[1:0])
            2'b00:   byte_enable = byte_en_t'(4'b0001 << ea[1:0]);
            2'b01:   byte_enable = byte_en_t'(4'b0011 << ea[1:0]);
            default: byte_enable = 4'b1111;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   misaligned = 1'b0;
            2'b01:   misaligned = ea[0];
            default: misaligned = |ea[1:0];
        endcase
    end

    // addressed lanes brought down to bit 0
    assign load_lanes = load_word >> lane_shift;

    always_comb begin
        case (funct3)
            3'b000:  load_value = {{24{load_lanes[7]}}, load_lanes[7:0]};
            3'b001:  load_value = {{16{load_lanes[15]}}, load_lanes[15:0]};
            3'b100:  load_value = {24'h000000, load_lanes[7:0]};
            3'b101:  load_value = {16'h0000, load_lanes[15:0]};
            default: load_value = load_lanes;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire              clk,
    input  wire              reset_n,
    input  wire              ready,
    input  rv_pkg::word_t    read_data,
    input  wire              read_data_valid,
    output rv_pkg::word_t    addr,
    output rv_pkg::word_t    write_data,
    output rv_pkg::byte_en_t byte_enable,
    output logic             write_req,
    output logic             read_req,
    output logic             fault
);
    import rv_pkg::*;

    core_state_t state, state_next;
    word_t pc, pc_next;
    mem_req_t mem_req, mem_req_next;

    word_t instruction, instruction_next;
    alu_op_t alu_op, alu_op_next;
    word_t alu_lhs, alu_lhs_next, alu_rhs, alu_rhs_next, alu_res;
    word_t load_word, load_word_next;

    decoded_t dec;
    word_t rs1_value, rs2_value, shamt;
    word_t pc_plus4, branch_target, flow_pc, rd_value;
    logic rd_write, wb_commit, read_accept;

    word_t lsu_store_data, load_value;
    byte_en_t lsu_byte_enable;
    logic lsu_misaligned;

    function automatic word_t pick_operand(operand_sel_t sel, word_t reg_value, word_t imm,
                                           word_t pc_value, word_t shift_amount);
        case (sel)
            sel_imm:   return imm;
            sel_pc:    return pc_value;
            sel_shamt: return shift_amount;
            default:   return reg_value;
        endcase
    endfunction

    rv_decode decode_i (
        .instruction (instruction),
        .decoded     (dec)
    );

    rv_regfile regfile_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .rs1          (dec.rs1),
        .rs2          (dec.rs2),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .write_enable (wb_commit && rd_write),
        .rd           (dec.rd),
        .rd_value     (rd_value)
    );

    rv_alu alu_i (
        .op  (alu_op),
        .lhs (alu_lhs),
        .rhs (alu_rhs),
        .res (alu_res)
    );

    rv_lsu lsu_i (
        .ea          (alu_res),
        .funct3      (dec.funct3),
        .store_value (rs2_value),
        .load_word   (load_word),
        .store_data  (lsu_store_data),
        .byte_enable (lsu_byte_enable),
        .load_value  (load_value),
        .misaligned  (lsu_misaligned)
    );

    assign shamt = {{(xlen-5){1'b0}}, dec.rs2};
    assign pc_plus4 = pc + 32'd4;
    assign branch_target = pc + dec.branch_offset;

    // data counts once the read itself has been accepted
    assign read_accept = read_data_valid && (ready || !mem_req.read_req);

    // rd value and next pc for writeback
    always_comb begin
        flow_pc = pc_plus4;
        rd_write = 1'b0;
        rd_value = alu_res;
        case (dec.opcode)
            op_lui, op_auipc, op_imm, op_reg: rd_write = 1'b1;
            op_jal: begin
                rd_write = 1'b1;
                rd_value = pc_plus4;
                flow_pc = alu_res;
            end
            op_jalr: begin
                rd_write = 1'b1;
                rd_value = pc_plus4;
                flow_pc = {alu_res[xlen-1:1], 1'b0};
            end
            op_branch: begin
                if (alu_res[0]) begin
                    flow_pc = branch_target;
                end
            end
            op_load: begin
                rd_write = 1'b1;
                rd_value = load_value;
            end
            default: rd_write = 1'b0;
        endcase
    end

    assign wb_commit = (state == st_writeback) && ready && (flow_pc[1:0] == 2'b00);

    always_comb begin
        state_next = state;
        pc_next = pc;
        mem_req_next = mem_req;
        instruction_next = instruction;
        alu_op_next = alu_op;
        alu_lhs_next = alu_lhs;
        alu_rhs_next = alu_rhs;
        load_word_next = load_word;

        case (state)
            st_fetch_setup: begin
                mem_req_next.addr = pc;
                mem_req_next.byte_enable = 4'hf;
                mem_req_next.read_req = 1'b1;
                state_next = st_fetch;
            end
            st_fetch: begin
                if (ready) begin
                    mem_req_next.read_req = 1'b0;
                end
                if (read_accept) begin
                    instruction_next = read_data;
                    state_next = st_decode;
                end
            end
            st_decode: begin
                alu_op_next = dec.alu_op;
                alu_lhs_next = pick_operand(dec.lhs_sel, rs1_value, dec.imm, pc, shamt);
                alu_rhs_next = pick_operand(dec.rhs_sel, rs2_value, dec.imm, pc, shamt);
                if (dec.illegal) begin
                    state_next = st_fault;
                end else if (dec.opcode == op_load) begin
                    state_next = st_mem_load;
                end else if (dec.opcode == op_store) begin
                    state_next = st_mem_store;
                end else begin
                    state_next = st_writeback;
                end
            end
            st_mem_load: begin
                if (lsu_misaligned) begin
                    state_next = st_fault;
                end else begin
                    mem_req_next.addr = {alu_res[xlen-1:2], 2'b00};
                    mem_req_next.byte_enable = lsu_byte_enable;
                    mem_req_next.read_req = 1'b1;
                    state_next = st_load_wait;
                end
            end
            st_load_wait: begin
                if (ready) begin
                    mem_req_next.read_req = 1'b0;
                end
                if (read_accept) begin
                    load_word_next = read_data;
                    state_next = st_writeback;
                end
            end
            st_mem_store: begin
                if (lsu_misaligned) begin
                    state_next = st_fault;
                end else begin
                    mem_req_next.addr = {alu_res[xlen-1:2], 2'b00};
                    mem_req_next.write_data = lsu_store_data;
                    mem_req_next.byte_enable = lsu_byte_enable;
                    mem_req_next.write_req = 1'b1;
                    state_next = st_writeback;
                end
            end
            st_writeback: begin
                if (flow_pc[1:0] != 2'b00) begin
                    state_next = st_fault;
                end else if (ready) begin
                    // store completes here, next fetch goes out on the same edge
                    mem_req_next.write_req = 1'b0;
                    pc_next = flow_pc;
                    mem_req_next.addr = flow_pc;
                    mem_req_next.byte_enable = 4'hf;
                    mem_req_next.read_req = 1'b1;
                    state_next = st_fetch;
                end
            end
            default: state_next = st_fault;
        endcase

        // no bus traffic once faulted
        if (state_next == st_fault) begin
            mem_req_next.read_req = 1'b0;
            mem_req_next.write_req = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_fetch_setup;
            pc <= reset_pc;
            mem_req <= '0;
        end else begin
            state <= state_next;
            pc <= pc_next;
            mem_req <= mem_req_next;
        end
    end

    always_ff @(posedge clk) begin
        instruction <= instruction_next;
        alu_op <= alu_op_next;
        alu_lhs <= alu_lhs_next;
        alu_rhs <= alu_rhs_next;
        load_word <= load_word_next;
    end

    assign addr = mem_req.addr;
    assign write_data = mem_req.write_data;
    assign byte_enable = mem_req.byte_enable;
    assign write_req = mem_req.write_req;
    assign read_req = mem_req.read_req;
    assign fault = (state == st_fault);

endmodule

`default_nettype wire

// File: test/rv_core_props.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_props (
    input wire              clk,
    input wire              reset_n,
    input wire              ready,
    input rv_pkg::word_t    addr,
    input rv_pkg::byte_en_t byte_enable,
    input wire              write_req,
    input wire              read_req,
    input wire              fault
);
    import rv_pkg::*;

    one_request: assert property (@(posedge clk) disable iff (!reset_n)
        !(read_req && write_req))
        else $error("read and write requested together");

    // request held until ready
    stable_request: assert property (@(posedge clk) disable iff (!reset_n)
        (read_req || write_req) && !ready |=> $stable(addr) && $stable(byte_enable))
        else $error("address or byte enables changed while waiting for ready");

    fault_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        fault |=> fault)
        else $error("fault dropped before reset");

    quiet_after_fault: assert property (@(posedge clk) disable iff (!reset_n)
        fault |-> !read_req && !write_req)
        else $error("bus request raised while faulted");

endmodule

bind rv_core rv_core_props props_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .ready       (ready),
    .addr        (addr),
    .byte_enable (byte_enable),
    .write_req   (write_req),
    .read_req    (read_req),
    .fault       (fault)
);

`default_nettype wire

// File: test/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam word_t data_base = 32'h2000_0000;
    localparam word_t done_addr = 32'h2000_00fc;
    localparam int stall_factor = 4;

    logic clk, reset_n, ready, read_data_valid;
    word_t read_data, addr, write_data;
    byte_en_t byte_enable;
    logic write_req, read_req, fault;

    word_t golden [0:127];
    word_t data_mem [0:63];
    logic read_pending, done;
    word_t read_addr, rnd;
    int cycles, limit, store_count, mismatch_count, other_count;

    rv_core dut_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .ready           (ready),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .addr            (addr),
        .write_data      (write_data),
        .byte_enable     (byte_enable),
        .write_req       (write_req),
        .read_req        (read_req),
        .fault           (fault)
    );

    always #10 clk = ~clk;

    function automatic word_t xorshift32(word_t x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic word_t mem_read(word_t a);
        if (a - reset_pc < 32'd256) return golden[(a - reset_pc) >> 2];
        if (a - data_base < 32'd256) return data_mem[(a - data_base) >> 2];
        return '0;
    endfunction

    function automatic string test_name(int idx);
        if (idx < 4) return "alu";
        if (idx < 7) return "branch_jump";
        if (idx < 9) return "store_lanes";
        return "load_extend";
    endfunction

    task automatic apply_write(word_t a, byte_en_t be, word_t d);
        int g;
        if (a == done_addr) begin
            done = 1'b1;
            return;
        end
        g = 67 + 3 * store_count;
        if (store_count >= golden[65]) begin
            $display("Error: store to %h beyond the expected store count", a);
            other_count++;
        end else begin
            assert ({a, 32'(be), d} == {golden[g], golden[g+1], golden[g+2]}) else begin
                $display("Mismatch %s: expected addr=%h be=%h data=%h, actual addr=%h be=%h data=%h",
                         test_name(store_count), golden[g], golden[g+1][3:0], golden[g+2],
                         a, be, d);
                mismatch_count++;
            end
        end
        store_count++;
        if (a - data_base < 32'd256) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) data_mem[(a - data_base) >> 2][8*i +: 8] = d[8*i +: 8];
            end
        end
    endtask

    // accepted requests sampled mid-cycle once outputs and ready have settled
    always @(negedge clk) begin
        if (reset_n && ready && read_req) begin
            read_pending = 1'b1;
            read_addr = addr;
        end
        if (reset_n && ready && write_req) begin
            apply_write(addr, byte_enable, write_data);
        end
    end

    always @(posedge clk) begin
        cycles++;
        #1;
        read_data_valid = read_pending;
        read_data = read_pending ? mem_read(read_addr) : '0;
        read_pending = 1'b0;
        rnd = xorshift32(rnd);
        ready = reset_n && (rnd[1:0] != 2'b00);
    end

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        ready = 1'b0;
        read_data = '0;
        read_data_valid = 1'b0;
        read_pending = 1'b0;
        done = 1'b0;
        rnd = 32'd10142;
        cycles = 0;
        store_count = 0;
        mismatch_count = 0;
        other_count = 0;
        for (int i = 0; i < 64; i++) data_mem[i] = '0;
        $readmemh("test/rv_core_golden.hex", golden);
        limit = 40 * int'(golden[64]) * stall_factor;

        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;

        while (!read_req && cycles < limit) @(negedge clk);
        assert (addr == reset_pc && byte_enable == 4'hf && !write_req && !fault) else begin
            $display("Mismatch first_fetch: expected addr=%h be=f, actual addr=%h be=%h",
                     reset_pc, addr, byte_enable);
            mismatch_count++;
        end

        while (!fault && !done && cycles < limit) @(negedge clk);
        if (cycles >= limit) begin
            $display("Error: timeout, the core neither faulted nor finished in %0d cycles", limit);
            other_count++;
        end else if (fault) begin
            repeat (20) begin
                @(negedge clk);
                assert (!read_req && !write_req) else begin
                    $display("Error: bus request seen after fault");
                    other_count++;
                end
            end
        end

        assert (store_count == golden[65]) else begin
            $display("Mismatch store_count: expected %0d, actual %0d", golden[65], store_count);
            mismatch_count++;
        end
        assert (fault == golden[66][0]) else begin
            $display("Mismatch fault: expected %0d, actual %0d", golden[66][0], fault);
            mismatch_count++;
        end

        $display("errors: mismatches=%0d other=%0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rv_core_golden.hex
// words 00..3f: program image loaded at reset_pc, one instruction per word
// words 40..42: program word count, expected store count, expected final fault
// words 43..: expected stores, one per line as addr byte_enable data
@00
200000B7 FFB00113 0020A023 40115193
0030A223 00112233 402082B3 0042C333
0060A423 00001397 0070A623 00020463
05500413 00021463 06600413 0080A823
008004EF 06600413 0090AA23 01048567
06600413 00A0AC23 027080A3 02709123
00209583 02B0A423 0010C603 02C0A623
0220D683 02108703 00E687B3 02F0A823
0020A803
@40
00000021 0000000C 00000001
// alu results, lui and auipc
20000000 0000000F FFFFFFFB
20000004 0000000F FFFFFFFD
20000008 0000000F 20000004
2000000C 0000000F 10001024
// branch marker and link registers
20000010 0000000F 00000055
20000014 0000000F 10000044
20000018 0000000F 10000050
// sb at offset 1, sh at offset 2
20000020 00000002 00102400
20000020 0000000C 10240000
// lh, lbu, then lhu plus lb
20000028 0000000F FFFFFFFF
2000002C 0000000F 000000FF
20000030 0000000F 00001048

// File: rv_core.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_lsu.sv
source/rv_core.sv
test/rv_core_props.sv
test/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the rv_core testbench with Verilator.
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module rv_core_tb -f rv_core.f -o vrv_core_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/vrv_core_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
exit 0
